// File: list.f
+incdir+src
src/backtrack_pkg.sv
src/response_fifo.sv
src/backtrack_fifo_lanes_response_signal.sv
src/lane_response_router.sv
src/engine_lanes_response.sv
verification/tb_engine_lanes_response.sv

// File: Makefile
TOP  := tb_engine_lanes_response
SRCS := $(shell grep -v '^+' list.f) src/backtrack_defs.svh

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
obj_dir/V$(TOP): list.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^Testbench passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: verification/tb_engine_lanes_response.sv
// Directed testbench for the engine to lane response slice
// Sends random words through the gated engine FIFO and checks each lane
// against a queue of expected words, oldest first

`timescale 1ns/1ps

`include "backtrack_defs.svh"

module tb_engine_lanes_response;

    import backtrack_pkg::*;

    localparam int NL         = `NUM_LANES_MAX;
    localparam int MAX_CYCLES = 2000;
    // Guard for a lane that never fills
    localparam int WAIT_LIMIT = 200;
    localparam fifo_state_t IDLE_FLAGS = '{dout: '0, valid: 1'b0, empty: 1'b1,
                                           full: 1'b0, prog_full: 1'b0};

    logic          ap_clk;
    logic          areset_backtrack;
    logic          configure_route_valid;
    route_config_t configure_route_in;
    logic          engine_in_wr_en;
    data_word_t    engine_in_data;
    fifo_state_t   engine_in_state;
    logic [NL-1:0] lane_rd_en;
    fifo_state_t   lane_state [NL-1:0];

    // Expected words per lane
    data_word_t exp_q [NL-1:0][$];

    integer seed;
    int     error_count  = 0;
    int     check_count  = 0;
    int     test_count   = 0;
    int     failed_tests = 0;
    int     cycle_count  = 0;
    logic   full_reported = 1'b0;

    engine_lanes_response engine_lanes_response_inst (
        .ap_clk                (ap_clk),
        .areset_backtrack      (areset_backtrack),
        .configure_route_valid (configure_route_valid),
        .configure_route_in    (configure_route_in),
        .engine_in_wr_en       (engine_in_wr_en),
        .engine_in_data        (engine_in_data),
        .engine_in_state       (engine_in_state),
        .lane_rd_en            (lane_rd_en),
        .lane_state            (lane_state)
    );

    initial begin
        ap_clk = 1'b0;
        forever #5 ap_clk = ~ap_clk;
    end

    // --------------------
    // Timeout and monitor
    // --------------------
    always @(posedge ap_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: run stopped after %0d cycles", MAX_CYCLES);
            $display("Testbench failed");
            $finish;
        end
    end

    // A lane at full means back-pressure came too late
    always @(negedge ap_clk) begin
        for (int i = 0; i < NL; i++) begin
            if (!areset_backtrack && lane_state[i].full && !full_reported) begin
                $display("Lane %0d reported full, words may have been dropped", i);
                error_count++;
                full_reported = 1'b1;
            end
        end
    end

    // --------------------
    // Compare tasks
    // --------------------
    task automatic check_word(string name, data_word_t got, data_word_t exp);
        check_count++;
        if (got !== exp) begin
            $display("Error: %s got 0x%08h expected 0x%08h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        check_count++;
        if (got !== exp) begin
            $display("Error: %s got 0x%0h expected 0x%0h", name, got, exp);
            error_count++;
        end
    endtask

    // Level flags only
    // dout and valid are checked on reads
    task automatic check_state(string name, fifo_state_t got, fifo_state_t exp);
        check_flag({name, ".empty"}, got.empty, exp.empty);
        check_flag({name, ".prog_full"}, got.prog_full, exp.prog_full);
        check_flag({name, ".full"}, got.full, exp.full);
    endtask

    function automatic fifo_state_t make_flags(logic empty, logic prog_full, logic full);
        fifo_state_t s;
        s           = IDLE_FLAGS;
        s.empty     = empty;
        s.prog_full = prog_full;
        s.full      = full;
        return s;
    endfunction

    task automatic check_lanes_idle(logic [NL-1:0] mask);
        for (int i = 0; i < NL; i++) begin
            if (mask[i]) begin
                check_state($sformatf("lane%0d", i), lane_state[i], IDLE_FLAGS);
            end
        end
    endtask

    // --------------------
    // Drivers
    // --------------------
    task automatic apply_reset();
        @(posedge ap_clk);
        areset_backtrack <= 1'b1;
        repeat (10) @(posedge ap_clk);
        areset_backtrack <= 1'b0;
        for (int i = 0; i < NL; i++) begin
            exp_q[i].delete();
        end
        @(negedge ap_clk);
    endtask

    task automatic configure_route(logic [`NUM_BUNDLES_MAX-1:0] bundle,
                                   logic [`NUM_LANES_MAX-1:0] lane);
        @(posedge ap_clk);
        configure_route_valid <= 1'b1;
        configure_route_in    <= '{id_bundle: bundle, id_lane: lane};
        @(posedge ap_clk);
        configure_route_valid <= 1'b0;
    endtask

    // Negative lane means no destination is expected yet
    task automatic send_words(int n, int lane);
        data_word_t w;
        for (int k = 0; k < n; k++) begin
            w = $random(seed);
            @(posedge ap_clk);
            engine_in_wr_en <= 1'b1;
            engine_in_data  <= w;
            if (lane >= 0) begin
                exp_q[lane].push_back(w);
            end
        end
        @(posedge ap_clk);
        engine_in_wr_en <= 1'b0;
    endtask

    task automatic wait_not_empty(int lane, output bit ok);
        int waited;
        waited = 0;
        @(negedge ap_clk);
        while (lane_state[lane].empty && waited < WAIT_LIMIT) begin
            @(negedge ap_clk);
            waited++;
        end
        ok = !lane_state[lane].empty;
        if (!ok) begin
            $display("Lane %0d stayed empty while %0d words were still expected",
                     lane, exp_q[lane].size());
            error_count++;
        end
    endtask

    // One read strobe per word
    // Word shows on dout the cycle after
    task automatic drain_lane(int lane);
        data_word_t exp;
        bit         ok;
        while (exp_q[lane].size() > 0) begin
            wait_not_empty(lane, ok);
            if (!ok) break;
            @(posedge ap_clk);
            lane_rd_en[lane] <= 1'b1;
            @(posedge ap_clk);
            lane_rd_en[lane] <= 1'b0;
            @(negedge ap_clk);
            exp = exp_q[lane].pop_front();
            check_flag($sformatf("lane%0d.valid", lane), lane_state[lane].valid, 1'b1);
            check_word($sformatf("lane%0d.dout", lane), lane_state[lane].dout, exp);
        end
        exp_q[lane].delete();
    endtask

    task automatic finish_test(string name, int errors_before);
        test_count++;
        if (error_count == errors_before) begin
            $display("Test %0d %s: pass", test_count, name);
        end else begin
            $display("Test %0d %s: FAIL", test_count, name);
            failed_tests++;
        end
    endtask

    // --------------------
    // Directed tests
    // --------------------
    task automatic test_reset_state();
        int errs;
        errs = error_count;
        check_state("engine", engine_in_state, IDLE_FLAGS);
        check_flag("engine.valid", engine_in_state.valid, 1'b0);
        for (int i = 0; i < NL; i++) begin
            check_flag($sformatf("lane%0d.valid", i), lane_state[i].valid, 1'b0);
        end
        check_lanes_idle('1);
        // No route yet so words stay in the engine
        send_words(3, -1);
        // Any pop would raise the engine valid
        for (int c = 0; c < 20; c++) begin
            @(negedge ap_clk);
            check_flag("engine.valid", engine_in_state.valid, 1'b0);
        end
        check_state("engine", engine_in_state, make_flags(1'b0, 1'b0, 1'b0));
        check_lanes_idle('1);
        apply_reset();
        check_state("engine", engine_in_state, IDLE_FLAGS);
        finish_test("reset state", errs);
    endtask

    task automatic test_routed_order();
        int         errs;
        data_word_t last_word;
        errs = error_count;
        configure_route(4'b0010, 4'b0100);
        send_words(6, 2);
        last_word = exp_q[2][$];
        drain_lane(2);
        // Engine read data holds the last word it popped
        check_word("engine.dout", engine_in_state.dout, last_word);
        check_lanes_idle('1);
        finish_test("routed order", errs);
    endtask

    task automatic test_back_pressure();
        int errs;
        int waited;
        errs   = error_count;
        waited = 0;
        send_words(14, 2);
        while (!lane_state[2].prog_full && waited < WAIT_LIMIT) begin
            @(negedge ap_clk);
            waited++;
        end
        if (!lane_state[2].prog_full) begin
            $display("Lane 2 never raised prog_full with 14 words queued");
            error_count++;
        end
        // In-flight words settle while the rest wait in the engine
        repeat (20) @(negedge ap_clk);
        check_state("lane2", lane_state[2], make_flags(1'b0, 1'b1, 1'b0));
        check_flag("engine.empty", engine_in_state.empty, 1'b0);
        drain_lane(2);
        repeat (10) @(negedge ap_clk);
        check_state("engine", engine_in_state, IDLE_FLAGS);
        check_lanes_idle('1);
        finish_test("back-pressure", errs);
    endtask

    task automatic test_non_matching_bundle();
        int errs;
        errs = error_count;
        // Bundle 0 has successor 4'b0010 so this falls back to the last lane
        configure_route(4'b0001, 4'b0001);
        send_words(5, 3);
        drain_lane(3);
        check_lanes_idle('1);
        finish_test("non-matching bundle", errs);
    endtask

    task automatic test_reconfiguration();
        int errs;
        errs = error_count;
        configure_route(4'b0010, 4'b0001);
        send_words(4, 0);
        drain_lane(0);
        check_lanes_idle('1);
        configure_route(4'b0010, 4'b0010);
        send_words(4, 1);
        drain_lane(1);
        check_lanes_idle('1);
        finish_test("reconfiguration", errs);
    endtask

    initial begin
        seed                  = 32'h98a11f9f;
        areset_backtrack      = 1'b1;
        configure_route_valid = 1'b0;
        configure_route_in    = '0;
        engine_in_wr_en       = 1'b0;
        engine_in_data        = '0;
        lane_rd_en            = '0;
        apply_reset();
        test_reset_state();
        test_routed_order();
        test_back_pressure();
        test_non_matching_bundle();
        test_reconfiguration();
        repeat (5) @(negedge ap_clk);
        $display("Tests %0d, failed %0d, checks %0d, errors %0d",
                 test_count, failed_tests, check_count, error_count);
        if (error_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: src/engine_lanes_response.sv
// Top of the response slice
// Engine input FIFO -> gated pop -> router -> four lane FIFOs
// Lanes are drained by the lane_rd_en strobes

`timescale 1ns/1ps

`include "backtrack_defs.svh"

module engine_lanes_response (
    input  logic                         ap_clk,
    input  logic                         areset_backtrack,
    input  logic                         configure_route_valid,
    input  backtrack_pkg::route_config_t configure_route_in,
    input  logic                         engine_in_wr_en,
    input  backtrack_pkg::data_word_t    engine_in_data,
    output backtrack_pkg::fifo_state_t   engine_in_state,
    input  logic [`NUM_LANES_MAX-1:0]    lane_rd_en,
    output backtrack_pkg::fifo_state_t   lane_state [`NUM_LANES_MAX-1:0]
);

    import backtrack_pkg::*;

    // Engine side
    fifo_ctrl_t engine_request;
    fifo_ctrl_t engine_gated;
    fifo_ctrl_t engine_ctrl;

    // Lane side
    fifo_ctrl_t                router_ctrl [`NUM_LANES_MAX-1:0];
    fifo_ctrl_t                lane_ctrl   [`NUM_LANES_MAX-1:0];
    logic [`NUM_LANES_MAX-1:0] lane_sel;

    // --------------------
    // Engine FIFO
    // --------------------
    // Pop is requested whenever the engine holds data
    assign engine_request = '{
        wr_en: engine_in_wr_en,
        din:   engine_in_data,
        rd_en: ~engine_in_state.empty
    };

    // Actual pop comes back from the gate
    assign engine_ctrl = '{
        wr_en: engine_in_wr_en,
        din:   engine_in_data,
        rd_en: engine_gated.rd_en
    };

    response_fifo engine_fifo_inst (
        .ap_clk           (ap_clk),
        .areset_backtrack (areset_backtrack),
        .ctrl             (engine_ctrl),
        .state            (engine_in_state)
    );

    // --------------------
    // Gate and router
    // --------------------
    backtrack_fifo_lanes_response_signal #(
        .ID_BUNDLE (0)
    ) backtrack_inst (
        .ap_clk                (ap_clk),
        .areset_backtrack      (areset_backtrack),
        .configure_route_valid (configure_route_valid),
        .configure_route_in    (configure_route_in),
        .engine_signals_in     (engine_request),
        .lane_signals_in       (lane_state),
        .engine_signals_out    (engine_gated),
        .lane_sel              (lane_sel)
    );

    lane_response_router router_inst (
        .ap_clk           (ap_clk),
        .areset_backtrack (areset_backtrack),
        .engine_state     (engine_in_state),
        .lane_sel         (lane_sel),
        .lane_ctrl        (router_ctrl)
    );

    // --------------------
    // Lane FIFOs
    // --------------------
    for (genvar i = 0; i < `NUM_LANES_MAX; i++) begin : g_lane
        // Writes from the router, reads from outside
        assign lane_ctrl[i] = '{
            wr_en: router_ctrl[i].wr_en,
            din:   router_ctrl[i].din,
            rd_en: lane_rd_en[i]
        };

        response_fifo lane_fifo_inst (
            .ap_clk           (ap_clk),
            .areset_backtrack (areset_backtrack),
            .ctrl             (lane_ctrl[i]),
            .state            (lane_state[i])
        );
    end

endmodule

// File: src/lane_response_router.sv
// Steers each popped engine word into its destination lane FIFO
// Word and lane_sel are captured together, the write follows a cycle later

`timescale 1ns/1ps

`include "backtrack_defs.svh"

module lane_response_router (
    input  logic                       ap_clk,
    input  logic                       areset_backtrack,
    input  backtrack_pkg::fifo_state_t engine_state,
    input  logic [`NUM_LANES_MAX-1:0]  lane_sel,
    output backtrack_pkg::fifo_ctrl_t  lane_ctrl [`NUM_LANES_MAX-1:0]
);

    import backtrack_pkg::*;

    // One-hot write strobe, one bit per lane
    logic [`NUM_LANES_MAX-1:0] wr_sel_reg;
    data_word_t                din_reg;

    // --------------------
    // Capture stage
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_backtrack) begin
            wr_sel_reg <= '0;
        end else if (engine_state.valid) begin
            wr_sel_reg <= lane_sel;
        end else begin
            wr_sel_reg <= '0;
        end
    end

    // Payload, no reset
    always_ff @(posedge ap_clk) begin
        if (engine_state.valid) begin
            din_reg <= engine_state.dout;
        end
    end

    // --------------------
    // Lane write ports
    // --------------------
    // Shared data bus, strobe picks the lane
    // rd_en is left idle here, lanes are drained from outside
    always_comb begin
        for (int i = 0; i < `NUM_LANES_MAX; i++) begin
            lane_ctrl[i].wr_en = wr_sel_reg[i];
            lane_ctrl[i].din   = din_reg;
            lane_ctrl[i].rd_en = 1'b0;
        end
    end

    a_single_lane_write: assert property (
        @(posedge ap_clk) disable iff (areset_backtrack)
        $onehot0(wr_sel_reg)
    ) else $error("router: more than one lane written");

    // Engine is only popped once routed, so every word has a home
    a_word_has_lane: assert property (
        @(posedge ap_clk) disable iff (areset_backtrack)
        engine_state.valid |=> $onehot(wr_sel_reg)
    ) else $error("router: engine word popped without a destination lane");

endmodule

// File: src/backtrack_fifo_lanes_response_signal.sv
// Route holder and read-enable gate for the engine response FIFO
// Picks the destination lane from the configured route and stalls the
// engine pop while that lane sits at prog_full

`timescale 1ns/1ps

`include "backtrack_defs.svh"

module backtrack_fifo_lanes_response_signal #(
    parameter int ID_BUNDLE = 0
) (
    input  logic                         ap_clk,
    input  logic                         areset_backtrack,
    input  logic                         configure_route_valid,
    input  backtrack_pkg::route_config_t configure_route_in,
    input  backtrack_pkg::fifo_ctrl_t    engine_signals_in,
    input  backtrack_pkg::fifo_state_t   lane_signals_in [`NUM_LANES_MAX-1:0],
    output backtrack_pkg::fifo_ctrl_t    engine_signals_out,
    output logic [`NUM_LANES_MAX-1:0]    lane_sel
);

    import backtrack_pkg::*;

    localparam int NB = `NUM_BUNDLES_MAX;
    localparam int NL = `NUM_LANES_MAX;

    // One-hot id of the successor bundle, wraps at the top
    localparam int          NEXT_BUNDLE    = (ID_BUNDLE + 1) % NB;
    localparam logic [NB-1:0] NEXT_ID_BUNDLE = NB'(1) << NEXT_BUNDLE;
    // Fallback destination
    localparam logic [NL-1:0] LAST_LANE      = NL'(1) << (NL - 1);

    route_config_t route_reg;
    logic          route_configured;
    logic          route_match;

    logic          req_reg;
    logic [NL-1:0] prog_full_reg;
    logic          gate_reg;

    // --------------------
    // Route register
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (configure_route_valid) begin
            route_reg <= configure_route_in;
        end
    end

    // Stays set until reset, later routes just overwrite
    always_ff @(posedge ap_clk) begin
        if (areset_backtrack) begin
            route_configured <= 1'b0;
        end else if (configure_route_valid) begin
            route_configured <= 1'b1;
        end
    end

    assign route_match = (route_reg.id_bundle == NEXT_ID_BUNDLE);

    // Destination decode
    // Unconfigured gives no lane, which also blocks the gate
    always_comb begin
        if (!route_configured) begin
            lane_sel = '0;
        end else if (route_match) begin
            lane_sel = route_reg.id_lane;
        end else begin
            lane_sel = LAST_LANE;
        end
    end

    // --------------------
    // Read gate pipeline
    // --------------------
    // Stage 1, request and lane flags
    always_ff @(posedge ap_clk) begin
        if (areset_backtrack) begin
            req_reg       <= 1'b0;
            prog_full_reg <= '0;
        end else begin
            req_reg <= engine_signals_in.rd_en;
            for (int i = 0; i < NL; i++) begin
                prog_full_reg[i] <= lane_signals_in[i].prog_full;
            end
        end
    end

    // Stage 2, mask by destination prog_full
    always_ff @(posedge ap_clk) begin
        if (areset_backtrack) begin
            gate_reg <= 1'b0;
        end else begin
            gate_reg <= req_reg & route_configured & ~|(lane_sel & prog_full_reg);
        end
    end

    // Stage 3, output register
    // Write fields stay idle, the top owns the engine write side
    always_ff @(posedge ap_clk) begin
        if (areset_backtrack) begin
            engine_signals_out <= '0;
        end else begin
            engine_signals_out.wr_en <= 1'b0;
            engine_signals_out.din   <= '0;
            engine_signals_out.rd_en <= gate_reg;
        end
    end

    // Config source must send a single lane for a matching bundle
    a_route_lane_onehot: assert property (
        @(posedge ap_clk) disable iff (areset_backtrack)
        (configure_route_valid && configure_route_in.id_bundle == NEXT_ID_BUNDLE)
            |-> $onehot(configure_route_in.id_lane)
    ) else $error("backtrack: configured id_lane is not one-hot");

    a_lane_sel_onehot: assert property (
        @(posedge ap_clk) disable iff (areset_backtrack)
        route_configured |-> $onehot(lane_sel)
    ) else $error("backtrack: lane_sel is not one-hot");

endmodule

// File: src/response_fifo.sv
// Synchronous response FIFO with registered read data
// Used for the engine input queue and for every lane queue
// dout/valid follow an accepted read by one cycle

`timescale 1ns/1ps

`include "backtrack_defs.svh"

module response_fifo (
    input  logic                       ap_clk,
    input  logic                       areset_backtrack,
    input  backtrack_pkg::fifo_ctrl_t  ctrl,
    output backtrack_pkg::fifo_state_t state
);

    import backtrack_pkg::*;

    localparam int ADDR_W = $clog2(`FIFO_DEPTH);
    localparam int CNT_W  = ADDR_W + 1;

    // Storage, no reset
    data_word_t        mem [`FIFO_DEPTH];

    logic [ADDR_W-1:0] wr_ptr;
    logic [ADDR_W-1:0] rd_ptr;
    // One extra bit so a full buffer is distinct from empty
    logic [CNT_W-1:0]  count;

    data_word_t        dout_reg;
    logic              valid_reg;

    logic              empty_flag;
    logic              full_flag;
    logic              wr_accept;
    logic              rd_accept;

    // --------------------
    // Level flags
    // --------------------
    assign empty_flag = (count == '0);
    assign full_flag  = (count == CNT_W'(`FIFO_DEPTH));

    // Write into full is dropped, read of empty ignored
    assign wr_accept = ctrl.wr_en & ~full_flag;
    assign rd_accept = ctrl.rd_en & ~empty_flag;

    // --------------------
    // Pointers and occupancy
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_backtrack) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_accept) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_accept) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Simultaneous read and write keeps count
            case ({wr_accept, rd_accept})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge ap_clk) begin
        if (wr_accept) begin
            mem[wr_ptr] <= ctrl.din;
        end
    end

    // --------------------
    // Read port
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (rd_accept) begin
            dout_reg <= mem[rd_ptr];
        end
    end

    // Valid marks the cycle dout holds a fresh word
    always_ff @(posedge ap_clk) begin
        if (areset_backtrack) begin
            valid_reg <= 1'b0;
        end else begin
            valid_reg <= rd_accept;
        end
    end

    always_comb begin
        state.dout      = dout_reg;
        state.valid     = valid_reg;
        state.empty     = empty_flag;
        state.full      = full_flag;
        state.prog_full = (count >= CNT_W'(`PROG_FULL_THRESH));
    end

    // Upstream must honour prog_full early enough that full is never hit
    a_no_write_when_full: assert property (
        @(posedge ap_clk) disable iff (areset_backtrack)
        ctrl.wr_en |-> !full_flag
    ) else $error("response_fifo: write to full FIFO dropped");

endmodule

// File: src/backtrack_pkg.sv
// Shared types for the engine to lane response path
// Import inside a module body, or use scoped names in port lists

`include "backtrack_defs.svh"

package backtrack_pkg;

    // Opaque response payload
    typedef logic [`DATA_W-1:0] data_word_t;

    // --------------------
    // Route configuration
    // --------------------
    // Both fields one-hot
    typedef struct packed {
        logic [`NUM_BUNDLES_MAX-1:0] id_bundle;
        logic [`NUM_LANES_MAX-1:0]   id_lane;
    } route_config_t;

    // --------------------
    // FIFO interface
    // --------------------
    // Strobes and write data into a FIFO
    typedef struct packed {
        logic       wr_en;
        data_word_t din;
        logic       rd_en;
    } fifo_ctrl_t;

    // Read data and level flags out of a FIFO
    typedef struct packed {
        data_word_t dout;
        logic       valid;
        logic       empty;
        logic       full;
        logic       prog_full;
    } fifo_state_t;

endpackage

// File: src/backtrack_defs.svh
// Sizing macros for the lane response path
// Include wherever a port width or FIFO limit is needed

`ifndef BACKTRACK_DEFS_SVH
`define BACKTRACK_DEFS_SVH

// Topology, one-hot id widths
`define NUM_LANES_MAX   4
`define NUM_BUNDLES_MAX 4

// Opaque response word
`define DATA_W 32

// --------------------
// FIFO sizing
// --------------------
// Entries per FIFO, must be a power of two
`define FIFO_DEPTH 16

// Occupancy that raises prog_full
// Leaves room for words still in flight after the gate drops
`define PROG_FULL_THRESH 8

`endif
